// File: filelist.f
rtl/reg_bank_pkg.sv
rtl/reg_rw.sv
rtl/reg_rwc.sv
rtl/reg_decode.sv
rtl/rstn_merge.sv
rtl/com_reg_bank.sv
tests/com_reg_bank_asserts.sv
tests/tb_com_reg_bank.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_com_reg_bank
FILELIST  := filelist.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Simulation completed successfully" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tests/tb_com_reg_bank.sv
`timescale 1ns/1ps
`default_nettype none

module tb_com_reg_bank;

    localparam int         NUM_OPS        = 2000;
    localparam int         TIMEOUT_CYCLES = 2 * NUM_OPS + 1000;
    localparam logic [7:0] DEV_ID         = 8'hC3;
    localparam reg_bank_pkg::reg_req_t IDLE = '0;

    logic                       clk;
    logic                       rst_n;
    reg_bank_pkg::reg_req_t     req;
    reg_bank_pkg::mode_en_t     mode_en;
    reg_bank_pkg::status1_evt_t evt1;
    reg_bank_pkg::status2_evt_t evt2;
    reg_bank_pkg::reg_rsp_t     rsp;
    reg_bank_pkg::reg_data_t    q_mode;
    reg_bank_pkg::reg_data_t    q_cfg1;
    reg_bank_pkg::reg_data_t    q_cfg2;
    reg_bank_pkg::reg_data_t    q_st1;
    reg_bank_pkg::reg_data_t    q_mask1;
    reg_bank_pkg::reg_data_t    q_st2;
    reg_bank_pkg::reg_data_t    q_mask2;
    logic                       soft_rst_n;

    // reference model state
    reg_bank_pkg::reg_data_t    m_mode;
    reg_bank_pkg::reg_data_t    m_cfg1;
    reg_bank_pkg::reg_data_t    m_cfg2;
    reg_bank_pkg::reg_data_t    m_st1;
    reg_bank_pkg::reg_data_t    m_mask1;
    reg_bank_pkg::reg_data_t    m_st2;
    reg_bank_pkg::reg_data_t    m_mask2;
    logic                       m_sync1;
    logic                       m_sync2;

    logic [31:0]                lfsr;
    logic                       evt_on;
    int                         cycle_cnt = 0;
    logic                       obs_rst_n;
    reg_bank_pkg::reg_data_t    obs_mode;
    reg_bank_pkg::reg_data_t    obs_cfg1;
    reg_bank_pkg::reg_data_t    rst_val [8];

    com_reg_bank #(
        .DEVICE_ID (DEV_ID)
    ) dut0 (
        .i_clk             (clk),
        .i_rst_n           (rst_n),
        .i_req             (req),
        .i_mode_en         (mode_en),
        .i_status1_evt     (evt1),
        .i_status2_evt     (evt2),
        .o_rsp             (rsp),
        .o_reg_mode        (q_mode),
        .o_reg_com_config1 (q_cfg1),
        .o_reg_com_config2 (q_cfg2),
        .o_reg_status1     (q_st1),
        .o_reg_mask1       (q_mask1),
        .o_reg_status2     (q_st2),
        .o_reg_mask2       (q_mask2),
        .o_rst_n           (soft_rst_n)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, run did not finish", cycle_cnt);
            $display("Simulation failed");
            $fatal(1);
        end else if (dut0.u_asserts.fail_cnt != 0) begin
            $display("bound protocol assertion failed at t=%0t", $time);
            $display("Simulation failed");
            $fatal(1);
        end
    end

    //========================================
    // stimulus helpers
    //========================================
    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    function automatic reg_bank_pkg::reg_req_t rd_req(input reg_bank_pkg::reg_addr_t a);
        reg_bank_pkg::reg_req_t r;
        r = '0;
        r.ren = 1'b1;
        r.addr = a;
        return r;
    endfunction

    function automatic reg_bank_pkg::reg_req_t wr_req(input reg_bank_pkg::reg_addr_t a,
                                                     input reg_bank_pkg::reg_data_t d);
        reg_bank_pkg::reg_req_t r;
        r = '0;
        r.wen = 1'b1;
        r.addr = a;
        r.wdata = d;
        return r;
    endfunction

    function automatic reg_bank_pkg::reg_addr_t pick_addr(input logic [3:0] idx,
                                                         input reg_bank_pkg::reg_addr_t alt);
        reg_bank_pkg::reg_addr_t a;
        case (idx)
            4'd0: a = reg_bank_pkg::ADDR_DEVICE_ID;
            4'd1: a = reg_bank_pkg::ADDR_MODE;
            4'd2: a = reg_bank_pkg::ADDR_COM_CONFIG1;
            4'd3: a = reg_bank_pkg::ADDR_COM_CONFIG2;
            4'd4: a = reg_bank_pkg::ADDR_STATUS1;
            4'd5: a = reg_bank_pkg::ADDR_MASK1;
            4'd6: a = reg_bank_pkg::ADDR_STATUS2;
            4'd7: a = reg_bank_pkg::ADDR_MASK2;
            default: a = alt;
        endcase
        return a;
    endfunction

    task automatic check_value(input string name, input logic [7:0] exp, input logic [7:0] got);
        assert (got === exp) else begin
            $display("[ERROR] t=%0t %s expected=%h actual=%h", $time, name, exp, got);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    //========================================
    // reference model
    //========================================
    function automatic reg_bank_pkg::reg_data_t model_read(input reg_bank_pkg::reg_addr_t a,
                                                          input reg_bank_pkg::mode_en_t me);
        reg_bank_pkg::reg_data_t v;
        v = 8'h00;
        // every mapped register reads in test or spi mode
        if (me.test || me.spi) begin
            case (a)
                reg_bank_pkg::ADDR_DEVICE_ID:   v = DEV_ID;
                reg_bank_pkg::ADDR_MODE:        v = m_mode;
                reg_bank_pkg::ADDR_COM_CONFIG1: v = m_cfg1;
                reg_bank_pkg::ADDR_COM_CONFIG2: v = m_cfg2;
                reg_bank_pkg::ADDR_STATUS1:     v = m_st1;
                reg_bank_pkg::ADDR_MASK1:       v = m_mask1;
                reg_bank_pkg::ADDR_STATUS2:     v = m_st2;
                reg_bank_pkg::ADDR_MASK2:       v = m_mask2;
                default:                        v = 8'h00;
            endcase
        end
        return v;
    endfunction

    function automatic logic model_wr_ok(input reg_bank_pkg::reg_addr_t a,
                                         input reg_bank_pkg::mode_en_t me);
        logic ok;
        case (a)
            reg_bank_pkg::ADDR_MODE: ok = me.test | me.cfg | me.spi;
            reg_bank_pkg::ADDR_COM_CONFIG1, reg_bank_pkg::ADDR_COM_CONFIG2,
            reg_bank_pkg::ADDR_MASK1, reg_bank_pkg::ADDR_MASK2: ok = me.test | me.cfg;
            reg_bank_pkg::ADDR_STATUS1, reg_bank_pkg::ADDR_STATUS2: ok = me.cfg | me.spi;
            default: ok = 1'b0;
        endcase
        return ok;
    endfunction

    // everything behind the merged reset, MODE bit 0 kept
    task automatic reset_others();
        m_mode = {7'h04, m_mode[0]};
        m_cfg1 = 8'h2B;
        m_cfg2 = 8'hFF;
        m_mask1 = 8'h00;
        m_mask2 = 8'h00;
        m_st1 = 8'h00;
        m_st2 = 8'h00;
        m_sync1 = 1'b0;
        m_sync2 = 1'b0;
    endtask

    task automatic step_model();
        logic                    we;
        logic                    clr_n;
        reg_bank_pkg::reg_data_t clr1;
        reg_bank_pkg::reg_data_t clr2;
        reg_bank_pkg::reg_data_t set1;
        we = req.wen && model_wr_ok(req.addr, mode_en);
        clr_n = rst_n && !m_mode[0];
        clr1 = (we && req.addr == reg_bank_pkg::ADDR_STATUS1) ? req.wdata : 8'h00;
        clr2 = (we && req.addr == reg_bank_pkg::ADDR_STATUS2) ? req.wdata : 8'h00;
        set1 = {evt1.bist_fail, 1'b0, evt1.pwm_mmerr, evt1.pwm_dterr, evt1.wdg_err,
                evt1.com_err, evt1.crc_err, evt1.spi_err};
        // registers move only once the merged reset was released
        if (m_sync2) begin
            if (we) begin
                case (req.addr)
                    reg_bank_pkg::ADDR_MODE:        m_mode[7:1] = req.wdata[7:1];
                    reg_bank_pkg::ADDR_COM_CONFIG1: m_cfg1 = req.wdata;
                    reg_bank_pkg::ADDR_COM_CONFIG2: m_cfg2 = req.wdata;
                    reg_bank_pkg::ADDR_MASK1:       m_mask1 = req.wdata;
                    reg_bank_pkg::ADDR_MASK2:       m_mask2 = req.wdata;
                    default: begin
                    end
                endcase
            end
            m_st1 = ((m_st1 & ~clr1) | set1) & 8'hBF;
            m_st2 = (m_st2 & ~clr2) | evt2;
        end
        if (we && req.addr == reg_bank_pkg::ADDR_MODE) begin
            m_mode[0] = req.wdata[0];
        end
        if (!clr_n) begin
            m_sync1 = 1'b0;
            m_sync2 = 1'b0;
        end else begin
            m_sync2 = m_sync1;
            m_sync1 = 1'b1;
        end
        // request bit pulls the reset in right after the edge
        if (m_mode[0]) begin
            reset_others();
        end
    endtask

    // one bus cycle from falling edge to falling edge
    task automatic run_cycle(input reg_bank_pkg::reg_req_t r, input reg_bank_pkg::mode_en_t me,
                             output reg_bank_pkg::reg_data_t rd);
        logic [31:0]             a;
        logic [31:0]             b;
        logic [31:0]             c;
        reg_bank_pkg::reg_data_t exp_rd;
        req = r;
        mode_en = me;
        if (evt_on) begin
            take_bits(15, a);
            take_bits(15, b);
            take_bits(15, c);
            // sparse, about one event in eight per bit
            evt1 = a[14:8] & b[14:8] & c[14:8];
            evt2 = a[7:0] & b[7:0] & c[7:0];
        end else begin
            evt1 = '0;
            evt2 = '0;
        end
        #2;
        exp_rd = r.ren ? model_read(r.addr, me) : 8'h00;
        check_value("o_rsp.wack", 8'(r.wen), 8'(rsp.wack));
        check_value("o_rsp.rack", 8'(r.ren), 8'(rsp.rack));
        check_value("o_rsp.rdata", exp_rd, rsp.rdata);
        check_value("o_reg_mode", m_mode, q_mode);
        check_value("o_reg_com_config1", m_cfg1, q_cfg1);
        check_value("o_reg_com_config2", m_cfg2, q_cfg2);
        check_value("o_reg_status1", m_st1, q_st1);
        check_value("o_reg_mask1", m_mask1, q_mask1);
        check_value("o_reg_status2", m_st2, q_st2);
        check_value("o_reg_mask2", m_mask2, q_mask2);
        check_value("o_rst_n", 8'(m_sync2), 8'(soft_rst_n));
        rd = rsp.rdata;
        obs_rst_n = soft_rst_n;
        obs_mode = q_mode;
        obs_cfg1 = q_cfg1;
        @(posedge clk);
        step_model();
        @(negedge clk);
    endtask

    //========================================
    // test sequence
    //========================================
    initial begin
        reg_bank_pkg::reg_req_t  r;
        reg_bank_pkg::mode_en_t  me;
        reg_bank_pkg::reg_data_t rd;
        reg_bank_pkg::reg_data_t wd;
        logic [31:0]             v;
        logic [31:0]             w;
        lfsr = 32'hc1c21919;
        rst_n = 1'b0;
        req = '0;
        mode_en = '0;
        evt1 = '0;
        evt2 = '0;
        evt_on = 1'b0;
        rst_val = '{DEV_ID, 8'h08, 8'h2B, 8'hFF, 8'h00, 8'h00, 8'h00, 8'h00};
        m_mode = 8'h08;
        reset_others();
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // reset values with all modes on
        for (int i = 0; i < 8; i++) begin
            run_cycle(rd_req(pick_addr(4'(i), 7'h00)), 3'b111, rd);
            check_value("o_rsp.rdata after reset", rst_val[i], rd);
        end

        // soft reset request and its release
        run_cycle(wr_req(reg_bank_pkg::ADDR_COM_CONFIG1, 8'h55), 3'b111, rd);
        run_cycle(wr_req(reg_bank_pkg::ADDR_MODE, 8'hF1), 3'b111, rd);
        run_cycle(IDLE, 3'b111, rd);
        check_value("o_rst_n in soft reset", 8'h00, 8'(obs_rst_n));
        check_value("o_reg_mode in soft reset", 8'h09, obs_mode);
        check_value("o_reg_com_config1 in soft reset", 8'h2B, obs_cfg1);
        run_cycle(wr_req(reg_bank_pkg::ADDR_MODE, 8'h00), 3'b111, rd);
        run_cycle(IDLE, 3'b111, rd);
        check_value("o_rst_n one edge after release", 8'h00, 8'(obs_rst_n));
        run_cycle(IDLE, 3'b111, rd);
        check_value("o_rst_n two edges after release", 8'h00, 8'(obs_rst_n));
        run_cycle(IDLE, 3'b111, rd);
        check_value("o_rst_n released", 8'h01, 8'(obs_rst_n));

        // random traffic under random modes and fault events
        evt_on = 1'b1;
        for (int i = 0; i < NUM_OPS; i++) begin
            take_bits(23, v);
            me = v[2:0];
            wd = v[22:15];
            r = '0;
            r.addr = pick_addr(v[7:4], v[14:8]);
            if (r.addr == reg_bank_pkg::ADDR_MODE) begin
                take_bits(2, w);
                wd[0] = wd[0] & w[0] & w[1];
            end
            r.ren = v[3];
            r.wen = !v[3];
            r.wdata = wd;
            run_cycle(r, me, rd);
            run_cycle(IDLE, me, rd);
        end

        if (dut0.u_asserts.fail_cnt == 0) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            $display("bound protocol assertions failed %0d times", dut0.u_asserts.fail_cnt);
            $display("Simulation failed");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire

// File: tests/com_reg_bank_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module com_reg_bank_asserts (
    input wire logic                   i_clk,
    input wire logic                   i_rst_n,
    input wire reg_bank_pkg::reg_req_t i_req,
    input wire reg_bank_pkg::reg_rsp_t i_rsp
);

    int fail_cnt = 0;

    // acks mirror the strobes in the same cycle
    wack_follows_wen: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_rsp.wack == i_req.wen)
        else begin
            $error("wack does not match wen");
            fail_cnt++;
        end

    rack_follows_ren: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_rsp.rack == i_req.ren)
        else begin
            $error("rack does not match ren");
            fail_cnt++;
        end

    // read bus idles at zero
    rdata_zero_idle: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !i_req.ren |-> i_rsp.rdata == '0)
        else begin
            $error("rdata is not zero without a read strobe");
            fail_cnt++;
        end

    no_dual_strobe: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(i_req.ren && i_req.wen))
        else begin
            $error("read and write strobes raised in the same cycle");
            fail_cnt++;
        end

endmodule

bind com_reg_bank com_reg_bank_asserts u_asserts (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_req   (i_req),
    .i_rsp   (o_rsp)
);

`default_nettype wire

// File: rtl/com_reg_bank.sv
`timescale 1ns/1ps
`default_nettype none

module com_reg_bank #(
    parameter reg_bank_pkg::reg_data_t DEVICE_ID = 8'h5A
) (
    input  wire logic                        i_clk,
    input  wire logic                        i_rst_n,
    input  wire reg_bank_pkg::reg_req_t      i_req,
    input  wire reg_bank_pkg::mode_en_t      i_mode_en,
    input  wire reg_bank_pkg::status1_evt_t  i_status1_evt,
    input  wire reg_bank_pkg::status2_evt_t  i_status2_evt,
    output reg_bank_pkg::reg_rsp_t           o_rsp,
    output reg_bank_pkg::reg_data_t          o_reg_mode,
    output reg_bank_pkg::reg_data_t          o_reg_com_config1,
    output reg_bank_pkg::reg_data_t          o_reg_com_config2,
    output reg_bank_pkg::reg_data_t          o_reg_status1,
    output reg_bank_pkg::reg_data_t          o_reg_mask1,
    output reg_bank_pkg::reg_data_t          o_reg_status2,
    output reg_bank_pkg::reg_data_t          o_reg_mask2,
    output logic                             o_rst_n
);

    logic                    rst_n;
    reg_bank_pkg::reg_data_t wdata;
    logic                    we_mode;
    logic                    we_com_config1;
    logic                    we_com_config2;
    logic                    we_status1;
    logic                    we_mask1;
    logic                    we_status2;
    logic                    we_mask2;
    reg_bank_pkg::reg_data_t reg_mode;
    reg_bank_pkg::reg_data_t status1_set;
    reg_bank_pkg::reg_data_t status2_set;

    //========================================
    // decode and reset merge
    //========================================
    reg_decode #(
        .DEVICE_ID (DEVICE_ID)
    ) u_decode (
        .i_req             (i_req),
        .i_mode_en         (i_mode_en),
        .i_reg_mode        (reg_mode),
        .i_reg_com_config1 (o_reg_com_config1),
        .i_reg_com_config2 (o_reg_com_config2),
        .i_reg_status1     (o_reg_status1),
        .i_reg_mask1       (o_reg_mask1),
        .i_reg_status2     (o_reg_status2),
        .i_reg_mask2       (o_reg_mask2),
        .o_rsp             (o_rsp),
        .o_wdata           (wdata),
        .o_we_mode         (we_mode),
        .o_we_com_config1  (we_com_config1),
        .o_we_com_config2  (we_com_config2),
        .o_we_status1      (we_status1),
        .o_we_mask1        (we_mask1),
        .o_we_status2      (we_status2),
        .o_we_mask2        (we_mask2)
    );

    // mode bit 0 requests the soft reset
    rstn_merge u_rstn_merge (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_srst  (reg_mode[0]),
        .o_rst_n (rst_n)
    );

    assign o_rst_n = rst_n;

    //========================================
    // storage
    //========================================
    reg_rw #(
        .WIDTH     (7),
        .RESET_VAL (reg_bank_pkg::RST_MODE[7:1])
    ) u_mode_hi (
        .i_clk   (i_clk),
        .i_rst_n (rst_n),
        .i_we    (we_mode),
        .i_wdata (wdata[7:1]),
        .o_q     (reg_mode[7:1])
    );

    // only the hard reset clears the request bit
    reg_rw #(
        .WIDTH     (1),
        .RESET_VAL (reg_bank_pkg::RST_MODE[0])
    ) u_mode_lo (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_we    (we_mode),
        .i_wdata (wdata[0]),
        .o_q     (reg_mode[0])
    );

    assign o_reg_mode = reg_mode;

    reg_rw #(
        .WIDTH     (reg_bank_pkg::REG_DW),
        .RESET_VAL (reg_bank_pkg::RST_COM_CONFIG1)
    ) u_com_config1 (
        .i_clk   (i_clk),
        .i_rst_n (rst_n),
        .i_we    (we_com_config1),
        .i_wdata (wdata),
        .o_q     (o_reg_com_config1)
    );

    reg_rw #(
        .WIDTH     (reg_bank_pkg::REG_DW),
        .RESET_VAL (reg_bank_pkg::RST_COM_CONFIG2)
    ) u_com_config2 (
        .i_clk   (i_clk),
        .i_rst_n (rst_n),
        .i_we    (we_com_config2),
        .i_wdata (wdata),
        .o_q     (o_reg_com_config2)
    );

    reg_rw #(
        .WIDTH     (reg_bank_pkg::REG_DW),
        .RESET_VAL (reg_bank_pkg::RST_MASK)
    ) u_mask1 (
        .i_clk   (i_clk),
        .i_rst_n (rst_n),
        .i_we    (we_mask1),
        .i_wdata (wdata),
        .o_q     (o_reg_mask1)
    );

    reg_rw #(
        .WIDTH     (reg_bank_pkg::REG_DW),
        .RESET_VAL (reg_bank_pkg::RST_MASK)
    ) u_mask2 (
        .i_clk   (i_clk),
        .i_rst_n (rst_n),
        .i_we    (we_mask2),
        .i_wdata (wdata),
        .o_q     (o_reg_mask2)
    );

    //========================================
    // sticky fault flags
    //========================================
    // bit 6 is a hole in the event map
    assign status1_set = {i_status1_evt.bist_fail, 1'b0, i_status1_evt[5:0]};
    assign status2_set = i_status2_evt;

    reg_rwc #(
        .RESERVED_MASK (8'h40)
    ) u_status1 (
        .i_clk   (i_clk),
        .i_rst_n (rst_n),
        .i_we    (we_status1),
        .i_wdata (wdata),
        .i_set   (status1_set),
        .o_q     (o_reg_status1)
    );

    reg_rwc #(
        .RESERVED_MASK (8'h00)
    ) u_status2 (
        .i_clk   (i_clk),
        .i_rst_n (rst_n),
        .i_we    (we_status2),
        .i_wdata (wdata),
        .i_set   (status2_set),
        .o_q     (o_reg_status2)
    );

endmodule

`default_nettype wire

// File: rtl/rstn_merge.sv
`timescale 1ns/1ps
`default_nettype none

module rstn_merge (
    input  wire logic i_clk,
    input  wire logic i_rst_n,
    input  wire logic i_srst,
    output logic      o_rst_n
);

    logic clr_n;
    logic sync1;
    logic sync2;

    // either cause pulls the reset in at once
    assign clr_n = i_rst_n & ~i_srst;

    // release lands on the second edge
    always_ff @(posedge i_clk or negedge clr_n) begin
        if (!clr_n) begin
            sync1 <= 1'b0;
            sync2 <= 1'b0;
        end else begin
            sync1 <= 1'b1;
            sync2 <= sync1;
        end
    end

    assign o_rst_n = sync2;

endmodule

`default_nettype wire

// File: rtl/reg_decode.sv
`timescale 1ns/1ps
`default_nettype none

module reg_decode #(
    parameter reg_bank_pkg::reg_data_t DEVICE_ID = 8'h5A
) (
    input  wire reg_bank_pkg::reg_req_t  i_req,
    input  wire reg_bank_pkg::mode_en_t  i_mode_en,
    input  wire reg_bank_pkg::reg_data_t i_reg_mode,
    input  wire reg_bank_pkg::reg_data_t i_reg_com_config1,
    input  wire reg_bank_pkg::reg_data_t i_reg_com_config2,
    input  wire reg_bank_pkg::reg_data_t i_reg_status1,
    input  wire reg_bank_pkg::reg_data_t i_reg_mask1,
    input  wire reg_bank_pkg::reg_data_t i_reg_status2,
    input  wire reg_bank_pkg::reg_data_t i_reg_mask2,
    output reg_bank_pkg::reg_rsp_t       o_rsp,
    output reg_bank_pkg::reg_data_t      o_wdata,
    output logic                         o_we_mode,
    output logic                         o_we_com_config1,
    output logic                         o_we_com_config2,
    output logic                         o_we_status1,
    output logic                         o_we_mask1,
    output logic                         o_we_status2,
    output logic                         o_we_mask2
);

    logic                    hit;
    reg_bank_pkg::perm_t     perm;
    reg_bank_pkg::reg_data_t rval;
    logic                    rd_ok;
    logic                    wr_ok;
    logic                    wr;

    //========================================
    // address map
    //========================================
    always_comb begin
        hit  = 1'b1;
        perm = '0;
        rval = '0;
        case (i_req.addr)
            reg_bank_pkg::ADDR_DEVICE_ID: begin
                perm = reg_bank_pkg::PERM_ID;
                rval = DEVICE_ID;
            end
            reg_bank_pkg::ADDR_MODE: begin
                perm = reg_bank_pkg::PERM_MODE;
                rval = i_reg_mode;
            end
            reg_bank_pkg::ADDR_COM_CONFIG1: begin
                perm = reg_bank_pkg::PERM_CONFIG;
                rval = i_reg_com_config1;
            end
            reg_bank_pkg::ADDR_COM_CONFIG2: begin
                perm = reg_bank_pkg::PERM_CONFIG;
                rval = i_reg_com_config2;
            end
            reg_bank_pkg::ADDR_STATUS1: begin
                perm = reg_bank_pkg::PERM_STATUS;
                rval = i_reg_status1;
            end
            reg_bank_pkg::ADDR_MASK1: begin
                perm = reg_bank_pkg::PERM_CONFIG;
                rval = i_reg_mask1;
            end
            reg_bank_pkg::ADDR_STATUS2: begin
                perm = reg_bank_pkg::PERM_STATUS;
                rval = i_reg_status2;
            end
            reg_bank_pkg::ADDR_MASK2: begin
                perm = reg_bank_pkg::PERM_CONFIG;
                rval = i_reg_mask2;
            end
            default: begin
                hit = 1'b0;
            end
        endcase
    end

    //========================================
    // mode permission check
    //========================================
    assign rd_ok = hit & ((perm.test_rd & i_mode_en.test) |
                          (perm.cfg_rd  & i_mode_en.cfg)  |
                          (perm.spi_rd  & i_mode_en.spi));
    assign wr_ok = hit & ((perm.test_wr & i_mode_en.test) |
                          (perm.cfg_wr  & i_mode_en.cfg)  |
                          (perm.spi_wr  & i_mode_en.spi));

    assign wr = i_req.wen & wr_ok;

    // one strobe per register
    assign o_we_mode        = wr & (i_req.addr == reg_bank_pkg::ADDR_MODE);
    assign o_we_com_config1 = wr & (i_req.addr == reg_bank_pkg::ADDR_COM_CONFIG1);
    assign o_we_com_config2 = wr & (i_req.addr == reg_bank_pkg::ADDR_COM_CONFIG2);
    assign o_we_status1     = wr & (i_req.addr == reg_bank_pkg::ADDR_STATUS1);
    assign o_we_mask1       = wr & (i_req.addr == reg_bank_pkg::ADDR_MASK1);
    assign o_we_status2     = wr & (i_req.addr == reg_bank_pkg::ADDR_STATUS2);
    assign o_we_mask2       = wr & (i_req.addr == reg_bank_pkg::ADDR_MASK2);

    assign o_wdata = i_req.wdata;

    // acks follow the strobes, denied reads give 0
    assign o_rsp.wack  = i_req.wen;
    assign o_rsp.rack  = i_req.ren;
    assign o_rsp.rdata = (i_req.ren & rd_ok) ? rval : '0;

endmodule

`default_nettype wire

// File: rtl/reg_rwc.sv
`timescale 1ns/1ps
`default_nettype none

module reg_rwc #(
    parameter reg_bank_pkg::reg_data_t RESERVED_MASK = '0
) (
    input  wire logic                    i_clk,
    input  wire logic                    i_rst_n,
    input  wire logic                    i_we,
    input  wire reg_bank_pkg::reg_data_t i_wdata,
    input  wire reg_bank_pkg::reg_data_t i_set,
    output reg_bank_pkg::reg_data_t      o_q
);

    reg_bank_pkg::reg_data_t q;
    reg_bank_pkg::reg_data_t clr;
    reg_bank_pkg::reg_data_t q_nxt;

    // write-one-to-clear
    assign clr = i_we ? i_wdata : '0;

    // event set overrides a clear in the same cycle
    assign q_nxt = ((q & ~clr) | i_set) & ~RESERVED_MASK;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            q <= reg_bank_pkg::RST_STATUS;
        end else begin
            q <= q_nxt;
        end
    end

    assign o_q = q;

endmodule

`default_nettype wire

// File: rtl/reg_rw.sv
`timescale 1ns/1ps
`default_nettype none

module reg_rw #(
    parameter int               WIDTH     = 8,
    parameter logic [WIDTH-1:0] RESET_VAL = '0
) (
    input  wire logic             i_clk,
    input  wire logic             i_rst_n,
    input  wire logic             i_we,
    input  wire logic [WIDTH-1:0] i_wdata,
    output logic      [WIDTH-1:0] o_q
);

    logic [WIDTH-1:0] q;

    // plain storage, load on decoded strobe
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            q <= RESET_VAL;
        end else if (i_we) begin
            q <= i_wdata;
        end
    end

    assign o_q = q;

endmodule

`default_nettype wire

// File: rtl/reg_bank_pkg.sv
`default_nettype none

package reg_bank_pkg;

    //========================================
    // widths and types
    //========================================
    localparam int REG_AW = 7;
    localparam int REG_DW = 8;

    typedef logic [REG_AW-1:0] reg_addr_t;
    typedef logic [REG_DW-1:0] reg_data_t;

    // register map
    localparam reg_addr_t ADDR_DEVICE_ID   = 7'h00;
    localparam reg_addr_t ADDR_MODE        = 7'h01;
    localparam reg_addr_t ADDR_COM_CONFIG1 = 7'h02;
    localparam reg_addr_t ADDR_COM_CONFIG2 = 7'h03;
    localparam reg_addr_t ADDR_STATUS1     = 7'h08;
    localparam reg_addr_t ADDR_MASK1       = 7'h09;
    localparam reg_addr_t ADDR_STATUS2     = 7'h0A;
    localparam reg_addr_t ADDR_MASK2       = 7'h0B;

    // reset values, MODE bit 0 clear
    localparam reg_data_t RST_MODE        = 8'h08;
    localparam reg_data_t RST_COM_CONFIG1 = 8'h2B;
    localparam reg_data_t RST_COM_CONFIG2 = 8'hFF;
    localparam reg_data_t RST_MASK        = 8'h00;
    localparam reg_data_t RST_STATUS      = 8'h00;

    //========================================
    // access modes and permissions
    //========================================
    typedef struct packed {
        logic test;
        logic cfg;
        logic spi;
    } mode_en_t;

    typedef struct packed {
        logic test_wr;
        logic cfg_wr;
        logic spi_wr;
        logic test_rd;
        logic cfg_rd;
        logic spi_rd;
    } perm_t;

    localparam perm_t PERM_MODE   = '{1'b1, 1'b1, 1'b1, 1'b1, 1'b0, 1'b1};
    localparam perm_t PERM_CONFIG = '{1'b1, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1};
    localparam perm_t PERM_STATUS = '{1'b0, 1'b1, 1'b1, 1'b1, 1'b0, 1'b1};
    localparam perm_t PERM_ID     = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b1};

    //========================================
    // host bus and fault events
    //========================================
    typedef struct packed {
        logic      ren;
        logic      wen;
        reg_addr_t addr;
        reg_data_t wdata;
    } reg_req_t;

    typedef struct packed {
        logic      wack;
        logic      rack;
        reg_data_t rdata;
    } reg_rsp_t;

    // STATUS1 bit 6 has no event
    typedef struct packed {
        logic bist_fail;
        logic pwm_mmerr;
        logic pwm_dterr;
        logic wdg_err;
        logic com_err;
        logic crc_err;
        logic spi_err;
    } status1_evt_t;

    typedef struct packed {
        logic hv_scp_flt;
        logic hv_desat_flt;
        logic hv_oc;
        logic hv_ot;
        logic hv_vcc_ov;
        logic hv_vcc_uv;
        logic lv_vsup_ov;
        logic lv_vsup_uv;
    } status2_evt_t;

endpackage

`default_nettype wire
